// File: filelist.f
issue_pkg.sv
reservation_station.sv
int_alu.sv
int_mul.sv
result_bus.sv
int_issue_cluster.sv
int_issue_cluster_asserts.sv
int_issue_cluster_tb.sv

// File: int_issue_cluster_tb.sv
`timescale 1ns/10ps

module int_issue_cluster_tb;
    import issue_pkg::*;

    localparam int  clk_half  = 20;
    localparam int  drive_dly = 2;
    localparam int  max_wait  = 400;
    localparam pc_t pc_base   = 32'h0000_1000;

    logic      clk;
    logic      reset;
    logic      dispatch_valid;
    dispatch_t dispatch;
    logic      rs_full;
    cdb_t      cdb;

    data_t                 exp_value [1 << tag_w];
    logic [(1<<tag_w)-1:0] outstanding;
    logic [(1<<tag_w)-1:0] done;          // broadcast already seen
    tag_t                  rd_of_seq [256];
    int                    seq_count;
    int                    next_tag;
    int                    pending_count;
    int                    errors;
    int                    timeouts;
    int                    broadcasts;
    integer                seed;

    int_issue_cluster u_int_issue_cluster (
        .clk            (clk),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .rs_full        (rs_full),
        .cdb            (cdb)
    );

    initial begin
        clk = 1'b0;
        forever #clk_half clk = ~clk;
    end

    function automatic data_t model_result(input op_t op, input data_t a, input data_t b);
        longint sa;
        longint sb;
        longint product;
        sa      = $signed(a);
        sb      = $signed(b);
        product = sa * sb;
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            op_sll:  return a << b[4:0];
            op_srl:  return a >> b[4:0];
            op_mul:  return product[31:0];
            op_mulh: return product[63:32];
            default: return '0;
        endcase
    endfunction

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            errors++;
            $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_tag(input string name, input tag_t got, input tag_t exp);
        if (got !== exp) begin
            errors++;
            $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic record_broadcast();
        int seq;
        seq = int'((cdb.pc - pc_base) >> 2);
        broadcasts++;
        if (outstanding[cdb.rd] !== 1'b1) begin
            errors++;
            $display("cdb broadcast for tag 0x%h, which is not outstanding", cdb.rd);
        end else begin
            if (seq < seq_count) begin
                check_tag("cdb.rd", cdb.rd, rd_of_seq[seq]);
            end else begin
                errors++;
                $display("cdb pc 0x%h belongs to no dispatched op", cdb.pc);
            end
            check_data("cdb.value", cdb.value, exp_value[cdb.rd]);
            outstanding[cdb.rd] = 1'b0;
            done[cdb.rd]        = 1'b1;
            pending_count--;
        end
    endtask

    always @(negedge clk) begin
        if (!reset && cdb.valid === 1'b1) begin
            record_broadcast();
        end
    end

    // dep < 0 takes the immediate, otherwise the source names that tag
    task automatic send_op(input op_t op, input int dep1, input data_t imm1,
                           input int dep2, input data_t imm2, output tag_t rd);
        data_t v1;
        data_t v2;
        int    waited;
        waited = 0;
        rd     = '0;
        while (rs_full && waited < max_wait) begin
            @(posedge clk);
            #drive_dly;
            waited++;
        end
        if (rs_full) begin
            timeouts++;
            $display("station stayed full, op %s was never dispatched", op.name());
            return;
        end
        rd = tag_t'(next_tag);
        next_tag++;
        v1 = (dep1 < 0) ? imm1 : exp_value[dep1];
        v2 = (dep2 < 0) ? imm2 : exp_value[dep2];
        exp_value[rd]          = model_result(op, v1, v2);
        outstanding[rd]        = 1'b1;
        done[rd]               = 1'b0;
        rd_of_seq[seq_count]   = rd;
        pending_count++;
        dispatch.op         = op;
        dispatch.pc         = pc_base + pc_t'(seq_count * 4);
        dispatch.rd         = rd;
        dispatch.src1_tag   = (dep1 < 0) ? '0 : tag_t'(dep1);
        dispatch.src2_tag   = (dep2 < 0) ? '0 : tag_t'(dep2);
        dispatch.src1_ready = (dep1 < 0) ? 1'b1 : done[dep1];
        dispatch.src2_ready = (dep2 < 0) ? 1'b1 : done[dep2];
        dispatch.src1_data  = dispatch.src1_ready ? v1 : data_t'($random(seed)); // junk if waiting
        dispatch.src2_data  = dispatch.src2_ready ? v2 : data_t'($random(seed));
        seq_count++;
        dispatch_valid = 1'b1;
        @(posedge clk);
        #drive_dly;
        dispatch_valid = 1'b0;
    endtask

    task automatic wait_tags(input string what);
        int waited;
        waited = 0;
        while (pending_count != 0 && waited < max_wait) begin
            @(posedge clk);
            #drive_dly;
            waited++;
        end
        if (pending_count != 0) begin
            timeouts++;
            $display("%s timed out with %0d tags never broadcast", what, pending_count);
            outstanding   = '0;
            pending_count = 0;
        end
        repeat (8) @(posedge clk);    // room for a stray duplicate
        #drive_dly;
    endtask

    task automatic test_reset_state();
        repeat (20) begin
            check_flag("rs_full", rs_full, 1'b0);
            check_flag("cdb.valid", cdb.valid, 1'b0);
            @(posedge clk);
            #drive_dly;
        end
    endtask

    task automatic test_independent_ops();
        tag_t rd;
        for (int r = 0; r < 2; r++) begin
            for (int k = 0; k <= int'(op_mulh); k++) begin
                send_op(op_t'(k), -1, $random(seed), -1, $random(seed), rd);
            end
        end
        wait_tags("independent ops");
    endtask

    task automatic test_wakeup_chain();
        op_t  chain_ops [8] = '{op_sub, op_xor, op_mul, op_srl, op_add, op_mulh, op_or, op_slt};
        tag_t first;
        tag_t prev;
        tag_t rd;
        send_op(op_add, -1, $random(seed), -1, $random(seed), first);
        prev = first;
        for (int k = 0; k < 8; k++) begin
            send_op(chain_ops[k], int'(prev), '0, (k % 2) ? int'(first) : -1,
                    $random(seed), rd);
            prev = rd;
        end
        wait_tags("wakeup chain");
    endtask

    task automatic test_mixed_units();
        op_t  mix_ops [12] = '{op_add, op_mul, op_mulh, op_sub, op_mul, op_and,
                               op_mulh, op_xor, op_add, op_mul, op_sll, op_or};
        tag_t tags [12];
        int   dep1;
        for (int k = 0; k < 12; k++) begin
            dep1 = (k >= 2 && k % 3 == 2) ? int'(tags[k-2]) : -1;
            send_op(mix_ops[k], dep1, $random(seed), -1, $random(seed), tags[k]);
        end
        wait_tags("mixed units");
    endtask

    task automatic test_capacity();
        tag_t  rd;
        data_t a;
        data_t b;
        int    producer;
        producer = next_tag + rs_entries - 1;   // last of the 16 tags handed out
        a = $random(seed);
        b = $random(seed);
        exp_value[producer] = model_result(op_add, a, b);
        done[producer]      = 1'b0;
        for (int k = 0; k < rs_entries - 1; k++) begin
            send_op(op_t'(k % 10), producer, '0, -1, $random(seed), rd);
        end
        check_flag("rs_full", rs_full, 1'b0);
        send_op(op_add, -1, a, -1, b, rd);
        check_flag("rs_full", rs_full, 1'b1);
        // this strobe lands while full and must vanish
        dispatch.op         = op_add;
        dispatch.pc         = pc_base - 4;
        dispatch.rd         = tag_t'((1 << tag_w) - 1);
        dispatch.src1_ready = 1'b1;
        dispatch.src2_ready = 1'b1;
        dispatch_valid      = 1'b1;
        @(posedge clk);
        #drive_dly;
        dispatch_valid = 1'b0;
        wait_tags("capacity");
    endtask

    initial begin
        seed           = 55186;
        errors         = 0;
        timeouts       = 0;
        broadcasts     = 0;
        seq_count      = 0;
        next_tag       = 1;
        pending_count  = 0;
        outstanding    = '0;
        done           = '0;
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        dispatch       = '0;
        repeat (10) @(posedge clk);
        #drive_dly;
        reset = 1'b0;
        test_reset_state();
        test_independent_ops();
        test_wakeup_chain();
        test_mixed_units();
        test_capacity();
        if (broadcasts != seq_count) begin
            errors++;
            $display("saw %0d broadcasts for %0d dispatched ops", broadcasts, seq_count);
        end
        $display("summary: %0d broadcasts, %0d errors, %0d timeouts",
                 broadcasts, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: int_issue_cluster_asserts.sv
`timescale 1ns/10ps

module int_issue_cluster_asserts (
    input logic clk,
    input logic reset,
    input logic alu_issue,
    input logic mul_issue,
    input logic alu_done,
    input logic mul_done,
    input logic rs_empty,
    input logic cdb_valid
);

    a_one_issue: assert property (@(posedge clk) disable iff (reset)
        !(alu_issue && mul_issue))
        else $error("both issue strobes high in the same cycle");

    a_one_result: assert property (@(posedge clk) disable iff (reset)
        !(alu_done && mul_done))
        else $error("both units completed in the same cycle");

    a_none_when_empty: assert property (@(posedge clk) disable iff (reset)
        rs_empty |=> !(alu_issue || mul_issue))
        else $error("issue seen while the station was empty");

    a_quiet_after_reset: assert property (@(posedge clk)
        reset |=> !cdb_valid)
        else $error("cdb valid while coming out of reset");

endmodule

bind int_issue_cluster int_issue_cluster_asserts u_cluster_asserts (
    .clk       (clk),
    .reset     (reset),
    .alu_issue (issue_alu_valid),
    .mul_issue (issue_mul_valid),
    .alu_done  (alu_result.valid),
    .mul_done  (mul_result.valid),
    .rs_empty  (~|u_reservation_station.busy),
    .cdb_valid (cdb.valid)
);

// File: int_issue_cluster.sv
`timescale 1ns/10ps

module int_issue_cluster (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 dispatch_valid,
    input  issue_pkg::dispatch_t dispatch,
    output logic                 rs_full,
    output issue_pkg::cdb_t      cdb
);
    import issue_pkg::*;

    logic         issue_alu_valid;
    logic         issue_mul_valid;
    issue_t       issue;          // shared by both units
    unit_result_t alu_result;
    unit_result_t mul_result;

    reservation_station u_reservation_station (
        .clk             (clk),
        .reset           (reset),
        .dispatch_valid  (dispatch_valid),
        .dispatch        (dispatch),
        .cdb             (cdb),
        .rs_full         (rs_full),
        .issue_alu_valid (issue_alu_valid),
        .issue_mul_valid (issue_mul_valid),
        .issue           (issue)
    );

    int_alu u_int_alu (
        .clk         (clk),
        .reset       (reset),
        .issue_valid (issue_alu_valid),
        .issue       (issue),
        .alu_result  (alu_result)
    );

    int_mul u_int_mul (
        .clk         (clk),
        .reset       (reset),
        .issue_valid (issue_mul_valid),
        .issue       (issue),
        .mul_result  (mul_result)
    );

    result_bus u_result_bus (
        .clk        (clk),
        .reset      (reset),
        .alu_result (alu_result),
        .mul_result (mul_result),
        .cdb        (cdb)       // wakeup and cluster output
    );

endmodule

// File: result_bus.sv
`timescale 1ns/10ps

module result_bus (
    input  logic                    clk,
    input  logic                    reset,
    input  issue_pkg::unit_result_t alu_result,
    input  issue_pkg::unit_result_t mul_result,
    output issue_pkg::cdb_t         cdb
);
    import issue_pkg::*;

    unit_result_t pick;
    logic         cdb_valid;
    tag_t         cdb_rd;
    pc_t          cdb_pc;
    data_t        cdb_value;

    // multiplier wins, booking keeps both from landing together
    assign pick = mul_result.valid ? mul_result : alu_result;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= alu_result.valid || mul_result.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (pick.valid) begin
            cdb_rd    <= pick.rd;
            cdb_pc    <= pick.pc;
            cdb_value <= pick.value;
        end
    end

    assign cdb = '{
        valid: cdb_valid,
        rd:    cdb_rd,
        pc:    cdb_pc,
        value: cdb_value
    };

endmodule

// File: int_mul.sv
`timescale 1ns/10ps

module int_mul (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    issue_valid,
    input  issue_pkg::issue_t       issue,
    output issue_pkg::unit_result_t mul_result
);
    import issue_pkg::*;

    typedef struct packed {
        logic high;
        tag_t rd;
        pc_t  pc;
    } mul_side_t;

    logic [mul_stages-1:0]          vld;
    mul_side_t                      side [mul_stages];   // rides along with the product
    logic signed [data_w/2-1:0]     s1_a_hi;
    logic signed [data_w-1:0]       s1_b;
    logic signed [data_w+data_w/2:0] s1_pp_lo;          // low half of a times b
    logic signed [2*data_w-1:0]     s2_prod;
    data_t                          s3_value;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            vld <= '0;
        end else begin
            vld <= {vld[mul_stages-2:0], issue_valid};
        end
    end

    always_ff @(posedge clk) begin
        side[0] <= '{high: issue.op == op_mulh, rd: issue.rd, pc: issue.pc};
        for (int s = 1; s < mul_stages; s++) begin
            side[s] <= side[s-1];
        end
    end

    always_ff @(posedge clk) begin
        // stage 1 low partial product, unsigned low half
        s1_a_hi  <= issue.src1[data_w-1:data_w/2];
        s1_b     <= issue.src2;
        s1_pp_lo <= $signed({1'b0, issue.src1[data_w/2-1:0]}) * $signed(issue.src2);
        // stage 2 signed high half and sum
        s2_prod  <= ((s1_a_hi * s1_b) <<< (data_w / 2)) + s1_pp_lo;
        // stage 3 word select
        s3_value <= side[1].high ? s2_prod[2*data_w-1:data_w] : s2_prod[data_w-1:0];
    end

    assign mul_result = '{
        valid: vld[mul_stages-1],
        rd:    side[mul_stages-1].rd,
        pc:    side[mul_stages-1].pc,
        value: s3_value
    };

endmodule

// File: int_alu.sv
`timescale 1ns/10ps

module int_alu (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    issue_valid,
    input  issue_pkg::issue_t       issue,
    output issue_pkg::unit_result_t alu_result
);
    import issue_pkg::*;

    data_t  result;
    shamt_t shamt;
    logic   valid_q;
    tag_t   rd_q;
    pc_t    pc_q;
    data_t  value_q;

    assign shamt = issue.src2[shamt_w-1:0];

    always_comb begin
        case (issue.op)
            op_add:  result = issue.src1 + issue.src2;
            op_sub:  result = issue.src1 - issue.src2;
            op_and:  result = issue.src1 & issue.src2;
            op_or:   result = issue.src1 | issue.src2;
            op_xor:  result = issue.src1 ^ issue.src2;
            op_slt:  result = ($signed(issue.src1) < $signed(issue.src2)) ? data_t'(1) : '0;
            op_sll:  result = issue.src1 << shamt;
            op_srl:  result = issue.src1 >> shamt;
            default: result = '0;   // mul ops go to int_mul
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            rd_q    <= issue.rd;
            pc_q    <= issue.pc;
            value_q <= result;
        end
    end

    assign alu_result = '{valid: valid_q, rd: rd_q, pc: pc_q, value: value_q};

endmodule

// File: reservation_station.sv
`timescale 1ns/10ps

module reservation_station (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 dispatch_valid,
    input  issue_pkg::dispatch_t dispatch,
    input  issue_pkg::cdb_t      cdb,
    output logic                 rs_full,
    output logic                 issue_alu_valid,
    output logic                 issue_mul_valid,
    output issue_pkg::issue_t    issue
);
    import issue_pkg::*;

    typedef struct packed {
        op_t   op;
        pc_t   pc;
        tag_t  rd;
        tag_t  src1_tag;
        tag_t  src2_tag;
        data_t src1_data;
        data_t src2_data;
    } rs_entry_t;

    function automatic logic is_mul_op(input op_t op);
        return (op == op_mul) || (op == op_mulh);
    endfunction

    rs_entry_t             entry [rs_entries];
    logic [rs_entries-1:0] busy;
    logic [rs_entries-1:0] src1_rdy;
    logic [rs_entries-1:0] src2_rdy;
    logic [rs_entries-1:0] older [rs_entries];   // older[i][j] set when j came before i
    logic [mul_stages-1:0] wb_booked;            // mul write-back slots ahead

    logic [rs_entries-1:0] alloc_oh;
    logic [rs_entries-1:0] wake1;
    logic [rs_entries-1:0] wake2;
    logic [rs_entries-1:0] eligible;
    logic [rs_entries-1:0] sel_oh;
    logic                  do_alloc;
    logic                  new_rdy1;
    logic                  new_rdy2;
    logic                  sel_valid;
    logic                  sel_is_mul;
    rs_entry_t             sel_entry;

    assign rs_full  = &busy;
    assign do_alloc = dispatch_valid && !rs_full;   // strobe while full is dropped

    // lowest clear bit of busy
    assign alloc_oh = do_alloc ? (~busy & (busy + 1'b1)) : '0;

    // dispatch sees the broadcast of its own cycle too
    assign new_rdy1 = dispatch.src1_ready || (cdb.valid && cdb.rd == dispatch.src1_tag);
    assign new_rdy2 = dispatch.src2_ready || (cdb.valid && cdb.rd == dispatch.src2_tag);

    always_comb begin
        for (int i = 0; i < rs_entries; i++) begin
            wake1[i] = cdb.valid && busy[i] && !src1_rdy[i] && cdb.rd == entry[i].src1_tag;
            wake2[i] = cdb.valid && busy[i] && !src2_rdy[i] && cdb.rd == entry[i].src2_tag;
        end
    end

    always_comb begin
        for (int i = 0; i < rs_entries; i++) begin
            eligible[i] = busy[i] && src1_rdy[i] && src2_rdy[i] &&
                          (is_mul_op(entry[i].op) || !wb_booked[mul_stages-2]); // mul owns slot
        end
        for (int i = 0; i < rs_entries; i++) begin
            sel_oh[i] = eligible[i] && !(|(eligible & older[i]));   // nothing older ready
        end
    end

    always_comb begin
        sel_entry = '0;
        for (int i = 0; i < rs_entries; i++) begin
            if (sel_oh[i]) begin
                sel_entry = entry[i];
            end
        end
    end

    assign sel_valid  = |sel_oh;
    assign sel_is_mul = is_mul_op(sel_entry.op);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy            <= '0;
            src1_rdy        <= '0;
            src2_rdy        <= '0;
            wb_booked       <= '0;
            issue_alu_valid <= 1'b0;
            issue_mul_valid <= 1'b0;
            for (int i = 0; i < rs_entries; i++) begin
                older[i] <= '0;
            end
        end else begin
            busy     <= (busy & ~sel_oh) | alloc_oh;
            src1_rdy <= ((src1_rdy | wake1) & ~alloc_oh) | (alloc_oh & {rs_entries{new_rdy1}});
            src2_rdy <= ((src2_rdy | wake2) & ~alloc_oh) | (alloc_oh & {rs_entries{new_rdy2}});
            for (int i = 0; i < rs_entries; i++) begin
                if (alloc_oh[i]) begin
                    older[i] <= busy;             // everyone already here is older
                end else begin
                    older[i] <= older[i] & ~alloc_oh;
                end
            end
            wb_booked <= (wb_booked >> 1) |
                         {sel_valid && sel_is_mul, {(mul_stages-1){1'b0}}};
            issue_alu_valid <= sel_valid && !sel_is_mul;
            issue_mul_valid <= sel_valid && sel_is_mul;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < rs_entries; i++) begin
            if (alloc_oh[i]) begin
                entry[i].op        <= dispatch.op;
                entry[i].pc        <= dispatch.pc;
                entry[i].rd        <= dispatch.rd;
                entry[i].src1_tag  <= dispatch.src1_tag;
                entry[i].src2_tag  <= dispatch.src2_tag;
                entry[i].src1_data <= dispatch.src1_ready ? dispatch.src1_data : cdb.value;
                entry[i].src2_data <= dispatch.src2_ready ? dispatch.src2_data : cdb.value;
            end else begin
                if (wake1[i]) begin
                    entry[i].src1_data <= cdb.value;
                end
                if (wake2[i]) begin
                    entry[i].src2_data <= cdb.value;
                end
            end
        end
        issue.op   <= sel_entry.op;
        issue.pc   <= sel_entry.pc;
        issue.rd   <= sel_entry.rd;
        issue.src1 <= sel_entry.src1_data;
        issue.src2 <= sel_entry.src2_data;
    end

endmodule

// File: issue_pkg.sv
package issue_pkg;

    localparam int rs_entries = 16;
    localparam int tag_w      = 7;
    localparam int data_w     = 32;
    localparam int pc_w       = 32;
    localparam int mul_stages = 3;
    localparam int shamt_w    = 5;

    typedef logic [tag_w-1:0]   tag_t;
    typedef logic [data_w-1:0]  data_t;
    typedef logic [pc_w-1:0]    pc_t;
    typedef logic [shamt_w-1:0] shamt_t;

    typedef enum logic [3:0] {
        op_add  = 4'd0,
        op_sub  = 4'd1,
        op_and  = 4'd2,
        op_or   = 4'd3,
        op_xor  = 4'd4,
        op_slt  = 4'd5,   // signed compare
        op_sll  = 4'd6,
        op_srl  = 4'd7,
        op_mul  = 4'd8,   // low product word
        op_mulh = 4'd9    // signed high word
    } op_t;

    typedef struct packed {
        op_t   op;
        pc_t   pc;
        tag_t  rd;
        tag_t  src1_tag;
        tag_t  src2_tag;
        data_t src1_data;
        data_t src2_data;
        logic  src1_ready;
        logic  src2_ready;
    } dispatch_t;

    typedef struct packed {
        op_t   op;
        pc_t   pc;
        tag_t  rd;
        data_t src1;
        data_t src2;
    } issue_t;

    typedef struct packed {
        logic  valid;
        tag_t  rd;
        pc_t   pc;
        data_t value;
    } unit_result_t;

    typedef struct packed {
        logic  valid;
        tag_t  rd;
        pc_t   pc;
        data_t value;
    } cdb_t;

endpackage
